//--- rtl/hdmi_rx_defines.svh
`ifndef HDMI_RX_DEFINES_SVH
`define HDMI_RX_DEFINES_SVH

// one tmds symbol, bit 0 goes out first on the wire
`define HDMI_SYM_W		10

// control symbols needed ahead of the two guard symbols
`define HDMI_PREAMBLE_LEN	8

// largest lane-to-lane skew the aligner can take out, in symbols
`define HDMI_MAX_SKEW		1

// pixel, line and frame counters
`define HDMI_CNT_W		16

//////////////////////////////////////////////////
// apb register map, byte offsets
//////////////////////////////////////////////////

// bit0 enable, rw
`define HDMI_REG_CTRL		8'h00
// bit0 locked, bits 3:1 lag as {red, grn, blu}
`define HDMI_REG_STATUS		8'h04
// valid pixels in the last finished line
`define HDMI_REG_LINE_LEN	8'h08
// lines counted in the last finished frame
`define HDMI_REG_FRAME_LINES	8'h0C
// frames seen since reset
`define HDMI_REG_FRAME_CNT	8'h10

`endif

//--- rtl/hdmi_rx_pkg.sv
`default_nettype none
`include "hdmi_rx_defines.svh"

package hdmi_rx_pkg;

	// what a received symbol turned out to be
	typedef enum logic [1:0] {
		SYM_CTL   = 2'd0,
		SYM_TERC4 = 2'd1,
		SYM_GUARD = 2'd2,
		SYM_VIDEO = 2'd3
	} sym_kind_t;

	// one decoded symbol of one channel
	typedef struct packed {
		sym_kind_t  kind;
		// only meaningful for control symbols
		logic [1:0] ctl;
		// pixel byte for video, low nibble for terc4
		logic [7:0] data;
		// set for 0b0100110011, clear for 0b1011001100
		logic       guard_hi;
	} tmds_sym_t;

	// three lanes after deskew
	typedef struct packed {
		tmds_sym_t blu;
		tmds_sym_t grn;
		tmds_sym_t red;
		// one cycle, with the first video triple of a line
		logic      video_start;
	} aligned_t;

	// outgoing vga style pixel
	typedef struct packed {
		logic       valid;
		logic       hsync;
		logic       vsync;
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} vga_pix_t;

	// everything software can read back
	typedef struct packed {
		logic                   locked;
		// {red, grn, blu}
		logic [2:0]             lag;
		logic [`HDMI_CNT_W-1:0] line_len;
		logic [`HDMI_CNT_W-1:0] frame_lines;
		logic [`HDMI_CNT_W-1:0] frame_cnt;
	} rx_status_t;

endpackage

`default_nettype wire

//--- rtl/tmds_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "hdmi_rx_defines.svh"

module tmds_decode
(
	input  wire                          i_clk,
	input  wire                          i_rst,
	input  wire [`HDMI_SYM_W-1:0]        i_sym,
	output hdmi_rx_pkg::tmds_sym_t       o_dec
);
	import hdmi_rx_pkg::*;

	// guard band codes
	localparam logic [`HDMI_SYM_W-1:0] GUARD_HI = 10'b0100110011;
	// same code as terc4 nibble 8, guard takes priority
	localparam logic [`HDMI_SYM_W-1:0] GUARD_LO = 10'b1011001100;

	logic       is_ctl;
	logic       is_terc;
	logic       is_guard;
	logic [1:0] ctl_val;
	logic [3:0] terc_val;
	logic [7:0] vid_inv;
	logic [7:0] vid_pix;
	tmds_sym_t  dec_next;

	// four control codes
	always_comb
	begin
		is_ctl  = 1'b1;
		ctl_val = 2'b00;
		case (i_sym)
		10'b1101010100: ctl_val = 2'b00;
		10'b0010101011: ctl_val = 2'b01;
		10'b0101010100: ctl_val = 2'b10;
		10'b1010101011: ctl_val = 2'b11;
		default:        is_ctl  = 1'b0;
		endcase
	end

	// terc4 table, nibble only, no island decode here
	always_comb
	begin
		is_terc  = 1'b1;
		terc_val = 4'h0;
		case (i_sym)
		10'b1010011100: terc_val = 4'h0;
		10'b1001100011: terc_val = 4'h1;
		10'b1011100100: terc_val = 4'h2;
		10'b1011100010: terc_val = 4'h3;
		10'b0101110001: terc_val = 4'h4;
		10'b0100011110: terc_val = 4'h5;
		10'b0110001110: terc_val = 4'h6;
		10'b0100111100: terc_val = 4'h7;
		10'b1011001100: terc_val = 4'h8;
		10'b0100111001: terc_val = 4'h9;
		10'b0110011100: terc_val = 4'hA;
		10'b1011000110: terc_val = 4'hB;
		10'b1010001110: terc_val = 4'hC;
		10'b1001110001: terc_val = 4'hD;
		10'b0101100011: terc_val = 4'hE;
		10'b1011000011: terc_val = 4'hF;
		default:        is_terc  = 1'b0;
		endcase
	end

	assign is_guard = (i_sym == GUARD_HI) || (i_sym == GUARD_LO);

	// bit 9 set means the low byte went out inverted
	assign vid_inv = i_sym[9] ? ~i_sym[7:0] : i_sym[7:0];

	// undo transition chain
	// bit 8 set -> xor, clear -> xnor
	always_comb
	begin
		vid_pix[0] = vid_inv[0];
		for (int i = 1; i < 8; i++)
		begin
			if (i_sym[8])
				vid_pix[i] = vid_inv[i] ^ vid_inv[i-1];
			else
				vid_pix[i] = ~(vid_inv[i] ^ vid_inv[i-1]);
		end
	end

	// classify, control first, anything unknown is video
	always_comb
	begin
		dec_next = '0;
		if (is_ctl)
		begin
			dec_next.kind = SYM_CTL;
			dec_next.ctl  = ctl_val;
		end
		else if (is_guard)
		begin
			dec_next.kind     = SYM_GUARD;
			dec_next.guard_hi = (i_sym == GUARD_HI);
		end
		else if (is_terc)
		begin
			dec_next.kind = SYM_TERC4;
			dec_next.data = {4'h0, terc_val};
		end
		else
		begin
			dec_next.kind = SYM_VIDEO;
			dec_next.data = vid_pix;
		end
	end

	// one cycle of decode latency
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			o_dec <= '0;
		else
			o_dec <= dec_next;
	end

endmodule

`default_nettype wire

//--- rtl/channel_align.sv
`timescale 1ns/1ps
`default_nettype none
`include "hdmi_rx_defines.svh"

module channel_align
(
	input  wire                          i_clk,
	input  wire                          i_rst,
	input  wire hdmi_rx_pkg::tmds_sym_t  i_blu,
	input  wire hdmi_rx_pkg::tmds_sym_t  i_grn,
	input  wire hdmi_rx_pkg::tmds_sym_t  i_red,
	output hdmi_rx_pkg::aligned_t        o_aligned,
	output logic                         o_locked,
	// {red, grn, blu}, 1 = lane finished a symbol early
	output logic [2:0]                   o_lag
);
	import hdmi_rx_pkg::*;

	localparam int RUN_W = $clog2(`HDMI_PREAMBLE_LEN + 1);
	// two stages for the latest lane, plus room for the early ones
	localparam int DEPTH = 2 + `HDMI_MAX_SKEW;

	// lane index 0 blu, 1 grn, 2 red
	tmds_sym_t        lane_in  [3];
	tmds_sym_t        lane_q   [3][DEPTH];
	tmds_sym_t        lane_out [3];
	logic [RUN_W-1:0] run_cnt  [3];
	logic [2:0]       ctl_ok;
	logic [2:0]       guard_ok;
	logic [2:0]       first_guard;
	logic [2:0]       done;
	logic [2:0]       done_d;
	logic [2:0]       hit;
	logic             all_hit;
	logic             fire;
	logic             fire_d;
	logic             miss;
	logic [2:0]       start_q;

	assign lane_in[0] = i_blu;
	assign lane_in[1] = i_grn;
	assign lane_in[2] = i_red;

	//////////////////////////////////////////////////
	// video preamble per lane
	//////////////////////////////////////////////////

	// video preamble is ctl 1000 -> grn 01, red 00
	// blue carries the syncs, any value goes
	always_comb
	begin
		ctl_ok[0]   = (i_blu.kind == SYM_CTL);
		ctl_ok[1]   = (i_grn.kind == SYM_CTL) && (i_grn.ctl == 2'b01);
		ctl_ok[2]   = (i_red.kind == SYM_CTL) && (i_red.ctl == 2'b00);
		guard_ok[0] = (i_blu.kind == SYM_GUARD) && !i_blu.guard_hi;
		guard_ok[1] = (i_grn.kind == SYM_GUARD) && i_grn.guard_hi;
		guard_ok[2] = (i_red.kind == SYM_GUARD) && !i_red.guard_hi;
	end

	// run counter saturates at the preamble length
	// first_guard marks a guard right after a long enough run
	always_ff @(posedge i_clk)
	begin
		for (int c = 0; c < 3; c++)
		begin
			if (i_rst)
			begin
				run_cnt[c]     <= '0;
				first_guard[c] <= 1'b0;
			end
			else
			begin
				if (!ctl_ok[c])
					run_cnt[c] <= '0;
				else if (run_cnt[c] != RUN_W'(`HDMI_PREAMBLE_LEN))
					run_cnt[c] <= run_cnt[c] + 1'b1;
				first_guard[c] <= guard_ok[c]
					&& (run_cnt[c] == RUN_W'(`HDMI_PREAMBLE_LEN));
			end
		end
	end

	// high on the second guard symbol
	assign done = guard_ok & first_guard;

	//////////////////////////////////////////////////
	// skew measurement
	//////////////////////////////////////////////////

	// lanes finished this cycle or the one before
	assign hit     = done | done_d;
	assign all_hit = &hit;
	// the latest lane closes the window
	assign fire    = all_hit && (|done);
	// an early lane whose partners never showed up in time
	// lanes that just closed a window do not count
	assign miss    = (|done_d) && !all_hit && !fire_d;

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			done_d   <= 3'b000;
			fire_d   <= 1'b0;
			start_q  <= 3'b000;
			o_locked <= 1'b0;
			o_lag    <= 3'b000;
		end
		else
		begin
			done_d  <= done;
			fire_d  <= fire;
			// fire -> first video next cycle -> two lane stages
			start_q <= {start_q[1:0], fire};
			if (fire)
			begin
				o_locked <= 1'b1;
				// finished last cycle and not now -> one symbol early
				o_lag    <= done_d & ~done;
			end
			else if (miss)
				o_locked <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// deskew
	//////////////////////////////////////////////////

	// plain shift lines, no reset on the symbol data
	always_ff @(posedge i_clk)
	begin
		for (int c = 0; c < 3; c++)
		begin
			lane_q[c][0] <= lane_in[c];
			for (int d = 1; d < DEPTH; d++)
				lane_q[c][d] <= lane_q[c][d-1];
		end
	end

	// lag 0 taps stage 1 (two regs), lag 1 taps stage 2
	always_comb
	begin
		for (int c = 0; c < 3; c++)
			lane_out[c] = lane_q[c][1 + o_lag[c]];
	end

	always_comb
	begin
		o_aligned.blu         = lane_out[0];
		o_aligned.grn         = lane_out[1];
		o_aligned.red         = lane_out[2];
		o_aligned.video_start = start_q[2];
	end

endmodule

`default_nettype wire

//--- rtl/vga_timing_out.sv
`timescale 1ns/1ps
`default_nettype none
`include "hdmi_rx_defines.svh"

module vga_timing_out
(
	input  wire                          i_clk,
	input  wire                          i_rst,
	input  wire hdmi_rx_pkg::aligned_t   i_aligned,
	input  wire                          i_locked,
	input  wire                          i_enable,
	output hdmi_rx_pkg::vga_pix_t        o_pix,
	output logic [`HDMI_CNT_W-1:0]       o_line_len,
	output logic [`HDMI_CNT_W-1:0]       o_frame_lines,
	output logic [`HDMI_CNT_W-1:0]       o_frame_cnt
);
	import hdmi_rx_pkg::*;

	localparam int CNT_W = `HDMI_CNT_W;

	logic             all_video;
	logic             in_video;
	logic             period;
	logic             line_end;
	logic             blu_ctl;
	logic             hs_next;
	logic             vs_next;
	logic             vs_rise;
	logic             pix_valid;
	logic             hsync_q;
	logic             vsync_q;
	logic [7:0]       red_q;
	logic [7:0]       grn_q;
	logic [7:0]       blu_q;
	logic [CNT_W-1:0] pix_cnt;
	logic [CNT_W-1:0] line_cnt;
	logic [CNT_W-1:0] line_next;

	//////////////////////////////////////////////////
	// video period and sync
	//////////////////////////////////////////////////

	assign all_video = (i_aligned.blu.kind == SYM_VIDEO)
		&& (i_aligned.grn.kind == SYM_VIDEO)
		&& (i_aligned.red.kind == SYM_VIDEO);

	// current triple belongs to the active line
	assign in_video = i_aligned.video_start || (period && all_video);
	// first non-video triple after a line
	assign line_end = period && !in_video;

	// blue control symbols carry {vsync, hsync}, hold otherwise
	assign blu_ctl = (i_aligned.blu.kind == SYM_CTL);
	assign hs_next = blu_ctl ? i_aligned.blu.ctl[0] : hsync_q;
	assign vs_next = blu_ctl ? i_aligned.blu.ctl[1] : vsync_q;
	assign vs_rise = vs_next && !vsync_q;

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			period    <= 1'b0;
			pix_valid <= 1'b0;
			hsync_q   <= 1'b0;
			vsync_q   <= 1'b0;
		end
		else
		begin
			period    <= in_video;
			// measurement keeps running, only the output is gated
			pix_valid <= in_video && i_enable && i_locked;
			hsync_q   <= hs_next;
			vsync_q   <= vs_next;
		end
	end

	// pixel bytes, no reset
	always_ff @(posedge i_clk)
	begin
		red_q <= i_aligned.red.data;
		grn_q <= i_aligned.grn.data;
		blu_q <= i_aligned.blu.data;
	end

	always_comb
	begin
		o_pix.valid = pix_valid;
		o_pix.hsync = hsync_q;
		o_pix.vsync = vsync_q;
		o_pix.red   = red_q;
		o_pix.green = grn_q;
		o_pix.blue  = blu_q;
	end

	//////////////////////////////////////////////////
	// line and frame measurement
	//////////////////////////////////////////////////

	// a line can end on the same triple that raises vsync
	assign line_next = line_cnt + CNT_W'(line_end);

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			pix_cnt       <= '0;
			line_cnt      <= '0;
			o_line_len    <= '0;
			o_frame_lines <= '0;
			o_frame_cnt   <= '0;
		end
		else
		begin
			// restart at each line
			if (in_video)
				pix_cnt <= i_aligned.video_start ? CNT_W'(1) : pix_cnt + 1'b1;
			if (line_end)
				o_line_len <= pix_cnt;
			// vsync rise closes the frame
			if (vs_rise)
			begin
				o_frame_lines <= line_next;
				o_frame_cnt   <= o_frame_cnt + 1'b1;
				line_cnt      <= '0;
			end
			else
				line_cnt <= line_next;
		end
	end

endmodule

`default_nettype wire

//--- rtl/hdmi_rx_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "hdmi_rx_defines.svh"

module hdmi_rx_regs
(
	input  wire                          i_clk,
	input  wire                          i_rst,
	input  wire                          i_psel,
	input  wire                          i_penable,
	input  wire                          i_pwrite,
	input  wire [7:0]                    i_paddr,
	input  wire [31:0]                   i_pwdata,
	output logic [31:0]                  o_prdata,
	output logic                         o_enable,
	input  wire hdmi_rx_pkg::rx_status_t i_status
);

	// zero fill for the counter registers
	localparam int PAD = 32 - `HDMI_CNT_W;

	logic        access;
	logic        wr_ctrl;
	logic [31:0] rd_mux;

	// no wait states, the access phase is the whole transfer
	assign access  = i_psel && i_penable;
	assign wr_ctrl = access && i_pwrite && (i_paddr == `HDMI_REG_CTRL);

	//////////////////////////////////////////////////
	// control register
	//////////////////////////////////////////////////

	// output comes up enabled
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			o_enable <= 1'b1;
		else if (wr_ctrl)
			o_enable <= i_pwdata[0];
	end

	//////////////////////////////////////////////////
	// read mux
	//////////////////////////////////////////////////

	// status offsets are read-only, writes there fall through
	always_comb
	begin
		case (i_paddr)
		`HDMI_REG_CTRL:
			rd_mux = {31'b0, o_enable};
		`HDMI_REG_STATUS:
			rd_mux = {28'b0, i_status.lag, i_status.locked};
		`HDMI_REG_LINE_LEN:
			rd_mux = {{PAD{1'b0}}, i_status.line_len};
		`HDMI_REG_FRAME_LINES:
			rd_mux = {{PAD{1'b0}}, i_status.frame_lines};
		`HDMI_REG_FRAME_CNT:
			rd_mux = {{PAD{1'b0}}, i_status.frame_cnt};
		// unmapped
		default:
			rd_mux = 32'b0;
		endcase
	end

	// bus reads zero outside the access phase
	assign o_prdata = access ? rd_mux : 32'b0;

endmodule

`default_nettype wire

//--- rtl/hdmi_rx_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "hdmi_rx_defines.svh"

module hdmi_rx_top
(
	input  wire                          i_clk,
	input  wire                          i_rst,
	// word aligned tmds symbols, one per clock
	input  wire [`HDMI_SYM_W-1:0]        i_tmds_blu,
	input  wire [`HDMI_SYM_W-1:0]        i_tmds_grn,
	input  wire [`HDMI_SYM_W-1:0]        i_tmds_red,
	// apb slave, zero wait states
	input  wire                          i_psel,
	input  wire                          i_penable,
	input  wire                          i_pwrite,
	input  wire [7:0]                    i_paddr,
	input  wire [31:0]                   i_pwdata,
	output wire [31:0]                   o_prdata,
	output hdmi_rx_pkg::vga_pix_t        o_pix
);
	import hdmi_rx_pkg::*;

	tmds_sym_t               sym_blu;
	tmds_sym_t               sym_grn;
	tmds_sym_t               sym_red;
	aligned_t                aligned;
	logic                    locked;
	logic [2:0]              lag;
	logic                    enable;
	logic [`HDMI_CNT_W-1:0]  line_len;
	logic [`HDMI_CNT_W-1:0]  frame_lines;
	logic [`HDMI_CNT_W-1:0]  frame_cnt;
	rx_status_t              status;

	//////////////////////////////////////////////////
	// per channel decode, one cycle
	//////////////////////////////////////////////////

	tmds_decode dec_blu (
		.i_clk (i_clk),
		.i_rst (i_rst),
		.i_sym (i_tmds_blu),
		.o_dec (sym_blu)
	);

	tmds_decode dec_grn (
		.i_clk (i_clk),
		.i_rst (i_rst),
		.i_sym (i_tmds_grn),
		.o_dec (sym_grn)
	);

	tmds_decode dec_red (
		.i_clk (i_clk),
		.i_rst (i_rst),
		.i_sym (i_tmds_red),
		.o_dec (sym_red)
	);

	// lane deskew, two cycles on the latest lane
	channel_align u_align (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_blu     (sym_blu),
		.i_grn     (sym_grn),
		.i_red     (sym_red),
		.o_aligned (aligned),
		.o_locked  (locked),
		.o_lag     (lag)
	);

	// pixel out, one more cycle
	vga_timing_out u_vga (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_aligned     (aligned),
		.i_locked      (locked),
		.i_enable      (enable),
		.o_pix         (o_pix),
		.o_line_len    (line_len),
		.o_frame_lines (frame_lines),
		.o_frame_cnt   (frame_cnt)
	);

	// gather status for software
	always_comb
	begin
		status.locked      = locked;
		status.lag         = lag;
		status.line_len    = line_len;
		status.frame_lines = frame_lines;
		status.frame_cnt   = frame_cnt;
	end

	hdmi_rx_regs u_regs (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_psel    (i_psel),
		.i_penable (i_penable),
		.i_pwrite  (i_pwrite),
		.i_paddr   (i_paddr),
		.i_pwdata  (i_pwdata),
		.o_prdata  (o_prdata),
		.o_enable  (enable),
		.i_status  (status)
	);

endmodule

`default_nettype wire

//--- bench/tmds_encode_model.svh
`ifndef TMDS_ENCODE_MODEL_SVH
`define TMDS_ENCODE_MODEL_SVH

// guard band codes, blue and red use the low one
localparam logic [9:0] GUARD_HI = 10'b0100110011;
localparam logic [9:0] GUARD_LO = 10'b1011001100;

// control, terc4 and guard codes that a video symbol must not take
localparam logic [9:0] RESERVED [21] = '{
	10'b1101010100, 10'b0010101011, 10'b0101010100, 10'b1010101011,
	10'b1010011100, 10'b1001100011, 10'b1011100100, 10'b1011100010,
	10'b0101110001, 10'b0100011110, 10'b0110001110, 10'b0100111100,
	10'b1011001100, 10'b0100111001, 10'b0110011100, 10'b1011000110,
	10'b1010001110, 10'b1001110001, 10'b0101100011, 10'b1011000011,
	10'b0100110011
};

function automatic logic [9:0] ctl_code(input logic [1:0] c);
	case (c)
	2'b00:   ctl_code = 10'b1101010100;
	2'b01:   ctl_code = 10'b0010101011;
	2'b10:   ctl_code = 10'b0101010100;
	default: ctl_code = 10'b1010101011;
	endcase
endfunction

function automatic logic is_reserved(input logic [9:0] s);
	is_reserved = 1'b0;
	for (int i = 0; i < 21; i++)
		if (s == RESERVED[i])
			is_reserved = 1'b1;
endfunction

// transition minimizing stage, then dc balance against the running disparity
task automatic encode_video(input logic [7:0] d, inout int disp, output logic [9:0] q);
	logic [8:0] qm;
	logic       use_xnor;
	int         n1;
	int         n0;
	use_xnor = ($countones(d) > 4) || (($countones(d) == 4) && !d[0]);
	qm[0] = d[0];
	for (int i = 1; i < 8; i++)
		qm[i] = use_xnor ? ~(qm[i-1] ^ d[i]) : (qm[i-1] ^ d[i]);
	qm[8] = !use_xnor;
	n1 = $countones(qm[7:0]);
	n0 = 8 - n1;
	if ((disp == 0) || (n1 == n0))
	begin
		q = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
		disp = qm[8] ? disp + n1 - n0 : disp + n0 - n1;
	end
	else if (((disp > 0) && (n1 > n0)) || ((disp < 0) && (n0 > n1)))
	begin
		q = {1'b1, qm[8], ~qm[7:0]};
		disp = disp + 2 * int'(qm[8]) + n0 - n1;
	end
	else
	begin
		q = {1'b0, qm[8], qm[7:0]};
		disp = disp - 2 * int'(!qm[8]) + n1 - n0;
	end
endtask

// random byte whose code stays clear of the reserved ones
task automatic pick_symbol(inout int disp, output logic [9:0] s, output logic [7:0] p);
	int          t;
	logic [31:0] rnd;
	t = disp;
	for (int k = 0; k < 64; k++)
	begin
		rnd = $random(seed);
		p = rnd[7:0];
		t = disp;
		encode_video(p, t, s);
		if (!is_reserved(s))
			break;
	end
	disp = t;
endtask

//////////////////////////////////////////////////
// line and frame builders
//////////////////////////////////////////////////

// control period, preamble guards, then video
task automatic send_line(input logic hs, input int npix, input logic en);
	int         d_b;
	int         d_g;
	int         d_r;
	logic [9:0] s_b;
	logic [9:0] s_g;
	logic [9:0] s_r;
	logic [7:0] p_b;
	logic [7:0] p_g;
	logic [7:0] p_r;
	d_b = 0;
	d_g = 0;
	d_r = 0;
	for (int i = 0; i < 12; i++)
		send_sym(ctl_code({1'b0, hs}), ctl_code(2'b01), ctl_code(2'b00));
	repeat (2)
		send_sym(GUARD_LO, GUARD_HI, GUARD_LO);
	for (int i = 0; i < npix; i++)
	begin
		pick_symbol(d_b, s_b, p_b);
		pick_symbol(d_g, s_g, p_g);
		pick_symbol(d_r, s_r, p_r);
		if (en)
			exp_q.push_back({hs, 1'b0, p_r, p_g, p_b});
		send_sym(s_b, s_g, s_r);
	end
endtask

// vsync raised on blue closes the frame
task automatic send_vsync_block();
	repeat (16)
		send_sym(ctl_code(2'b11), ctl_code(2'b01), ctl_code(2'b00));
endtask

`endif

//--- bench/hdmi_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "hdmi_rx_defines.svh"

module hdmi_rx_tb;
	import hdmi_rx_pkg::*;

	// skew is {red, grn, blu}, same order as the lag bits
	typedef struct packed {
		logic [2:0] skew;
		logic [7:0] pix;
		logic [7:0] lines;
		logic [3:0] frames;
		logic       en;
	} row_t;

	localparam int NROWS = 5;

	logic        i_clk;
	logic        i_rst;
	logic [9:0]  tmds_blu;
	logic [9:0]  tmds_grn;
	logic [9:0]  tmds_red;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	wire [31:0]  prdata;
	vga_pix_t    o_pix;

	row_t        rows [NROWS];
	logic [2:0]  skew;
	logic [9:0]  prev [3];
	logic [25:0] exp_q [$];
	logic [1:0]  sync_d;
	logic        valid_d;
	integer      seed;
	int          val_errs;
	int          misc_errs;

	hdmi_rx_top UUT (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_tmds_blu (tmds_blu),
		.i_tmds_grn (tmds_grn),
		.i_tmds_red (tmds_red),
		.i_psel     (psel),
		.i_penable  (penable),
		.i_pwrite   (pwrite),
		.i_paddr    (paddr),
		.i_pwdata   (pwdata),
		.o_prdata   (prdata),
		.o_pix      (o_pix)
	);

	initial
	begin
		i_clk = 1'b0;
		forever
			#5 i_clk = ~i_clk;
	end

	// one symbol per lane, late lanes get last cycle's symbol
	task automatic send_sym(input logic [9:0] b, input logic [9:0] g, input logic [9:0] r);
		@(negedge i_clk);
		tmds_blu = skew[0] ? prev[0] : b;
		tmds_grn = skew[1] ? prev[1] : g;
		tmds_red = skew[2] ? prev[2] : r;
		prev[0] = b;
		prev[1] = g;
		prev[2] = r;
	endtask

	`include "tmds_encode_model.svh"

	//////////////////////////////////////////////////
	// apb and checks
	//////////////////////////////////////////////////

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		@(negedge i_clk);
		psel   = 1'b1;
		pwrite = 1'b1;
		paddr  = addr;
		pwdata = data;
		@(negedge i_clk);
		penable = 1'b1;
		@(negedge i_clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		@(negedge i_clk);
		psel  = 1'b1;
		paddr = addr;
		@(negedge i_clk);
		penable = 1'b1;
		// prdata is combinational, settle inside the low phase
		#1 data = prdata;
		@(negedge i_clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] want);
		assert (got == want)
		else
		begin
			$display("FAIL %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, want);
			val_errs++;
		end
	endtask

	task automatic check_reg(input string what, input logic [7:0] addr,
		input logic [31:0] want);
		logic [31:0] d;
		apb_read(addr, d);
		check_value(what, d, want);
	endtask

	// output stage drains a few cycles behind the input
	task automatic wait_queue_empty();
		for (int n = 0; (n < 100) && (exp_q.size() != 0); n++)
			@(negedge i_clk);
		if (exp_q.size() != 0)
		begin
			$display("timeout: %0d expected pixels never came out", exp_q.size());
			misc_errs++;
			exp_q.delete();
		end
	endtask

	task automatic wait_frame_cnt(input int want);
		logic [31:0] d;
		d = '0;
		for (int n = 0; n < 20; n++)
		begin
			apb_read(`HDMI_REG_FRAME_CNT, d);
			if (d == 32'(want))
				break;
		end
		if (d != 32'(want))
		begin
			$display("timeout: frame counter stuck at %0d, waiting for %0d", d, want);
			misc_errs++;
		end
	endtask

	// scoreboard, every valid pixel pops one expected entry
	always @(negedge i_clk)
	begin : pix_monitor
		logic [25:0] got;
		logic [25:0] want;
		if (!i_rst && o_pix.valid)
		begin
			got = {o_pix.hsync, o_pix.vsync, o_pix.red, o_pix.green, o_pix.blue};
			// cycle ahead of a line's first pixel already shows its syncs
			if (!valid_d && (exp_q.size() != 0))
			begin
				want = exp_q[0];
				assert (sync_d == want[25:24])
				else
				begin
					$display("FAIL %0t: {hs,vs} 0x%0h ahead of a line, expected 0x%0h",
						$time, sync_d, want[25:24]);
					val_errs++;
				end
			end
			assert (exp_q.size() != 0)
			else
			begin
				$display("FAIL %0t: valid pixel 0x%0h outside a video period", $time, got);
				val_errs++;
			end
			if (exp_q.size() != 0)
			begin
				want = exp_q.pop_front();
				assert (got == want)
				else
				begin
					$display("FAIL %0t: pixel {hs,vs,r,g,b} 0x%0h, expected 0x%0h",
						$time, got, want);
					val_errs++;
				end
			end
		end
		sync_d  = {o_pix.hsync, o_pix.vsync};
		valid_d = o_pix.valid;
	end

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial
	begin : main
		int          frames_done;
		logic [2:0]  lag_exp;
		seed      = 32'h8a1b1b6d;
		val_errs  = 0;
		misc_errs = 0;
		skew      = 3'b000;
		i_rst     = 1'b1;
		tmds_blu  = ctl_code(2'b00);
		tmds_grn  = ctl_code(2'b01);
		tmds_red  = ctl_code(2'b00);
		prev[0]   = ctl_code(2'b00);
		prev[1]   = ctl_code(2'b01);
		prev[2]   = ctl_code(2'b00);
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = 8'h00;
		pwdata    = 32'h0;
		frames_done = 0;

		// skew, pixels, lines, frames, enable
		rows[0] = '{3'b000, 8'd12, 8'd3, 4'd2, 1'b1};
		rows[1] = '{3'b001, 8'd16, 8'd2, 4'd1, 1'b1};
		rows[2] = '{3'b110, 8'd10, 8'd3, 4'd1, 1'b1};
		rows[3] = '{3'b000, 8'd8, 8'd2, 4'd2, 1'b0};
		rows[4] = '{3'b111, 8'd9, 8'd2, 4'd1, 1'b1};

		repeat (16)
			@(posedge i_clk);
		@(negedge i_clk);
		i_rst = 1'b0;

		// state straight out of reset
		check_value("pixel valid/hsync/vsync", 32'({o_pix.valid, o_pix.hsync, o_pix.vsync}), 0);
		check_reg("status", `HDMI_REG_STATUS, 32'h0);
		check_reg("ctrl", `HDMI_REG_CTRL, 32'h1);
		check_reg("line length", `HDMI_REG_LINE_LEN, 32'h0);
		check_reg("frame lines", `HDMI_REG_FRAME_LINES, 32'h0);
		check_reg("frame count", `HDMI_REG_FRAME_CNT, 32'h0);

		for (int r = 0; r < NROWS; r++)
		begin
			apb_write(`HDMI_REG_CTRL, 32'(rows[r].en));
			check_reg("ctrl readback", `HDMI_REG_CTRL, 32'(rows[r].en));
			skew = rows[r].skew;
			// early lanes are the ones with no skew, only if some lane lags
			lag_exp = (|rows[r].skew) ? ~rows[r].skew : 3'b000;
			for (int f = 0; f < int'(rows[r].frames); f++)
			begin
				for (int l = 0; l < int'(rows[r].lines); l++)
					send_line(l[0], int'(rows[r].pix), rows[r].en);
				send_vsync_block();
				wait_queue_empty();
				frames_done++;
				wait_frame_cnt(frames_done);
				check_reg("line length", `HDMI_REG_LINE_LEN, 32'(rows[r].pix));
				check_reg("frame lines", `HDMI_REG_FRAME_LINES, 32'(rows[r].lines));
				if (f == 0)
					check_reg("status", `HDMI_REG_STATUS, 32'({lag_exp, 1'b1}));
			end
		end

		$display("errors: %0d value mismatches, %0d other failures", val_errs, misc_errs);
		if ((val_errs == 0) && (misc_errs == 0))
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+rtl
+incdir+bench
rtl/hdmi_rx_pkg.sv
rtl/tmds_decode.sv
rtl/channel_align.sv
rtl/vga_timing_out.sv
rtl/hdmi_rx_regs.sv
rtl/hdmi_rx_top.sv
bench/hdmi_rx_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the hdmi rx testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module hdmi_rx_tb -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vhdmi_rx_tb)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
	echo "simulation run returned status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q '^Simulation passed$'; then
	exit 0
fi

echo "pass message not found"
exit 1
